//--- include/ebus_macros.svh
`ifndef EBUS_MACROS_SVH
`define EBUS_MACROS_SVH

`define EBUS_DATA_W 36          // EBUS data path width
`define EBUS_CS_W 3             // Device select code width

// EBUS device select codes
// Code 0 and codes 4..7 have no device behind them
`define DEV_APR 3'd1            // APR condition unit
`define DEV_TIMER 3'd2          // Interval timer
`define DEV_EDP 3'd3            // EDP accumulator

`define TIMER_W 16              // Timer period and count width
`define APR_FLAGS_W 8           // Number of APR condition flags

`endif

//--- source/ebusPkg.sv
`include "ebus_macros.svh"

package ebusPkg;

  // EBUS function codes
  typedef enum logic [1:0] {
    DATAO = 2'b00,              // Data out to device
    DATAI = 2'b01,              // Data in from device
    CONO = 2'b10,               // Conditions out
    CONI = 2'b11                // Conditions in
  } tEbusFunc;

  // Diagnostic controller sequence
  typedef enum logic [1:0] {
    IDLE = 2'b00,               // Waiting for request
    STROBE = 2'b01,             // Command strobe on EBUS
    SAMPLE = 2'b10,             // Device drives read data
    RESP = 2'b11                // Holding response
  } tDiagState;

  // Broadcast to every device
  typedef struct packed {
    logic strobe;               // One cycle per EBUS cycle
    logic [`EBUS_CS_W-1:0] cs;  // Device select
    tEbusFunc func;
    logic [`EBUS_DATA_W-1:0] data;
  } tEbusCmd;

  // Per-device driver into the EBUS mux
  typedef struct packed {
    logic driving;              // Device owns EBUS this cycle
    logic [`EBUS_DATA_W-1:0] data;
  } tEBUSdriver;

  typedef struct packed {
    logic [`EBUS_CS_W-1:0] cs;
    tEbusFunc func;
    logic [`EBUS_DATA_W-1:0] data;
  } tDiagReq;

  typedef struct packed {
    logic [`EBUS_DATA_W-1:0] data; // Sampled EBUS, zero on writes
  } tDiagResp;

endpackage

//--- source/diagCtl.sv
`timescale 1ns/1ps
`include "ebus_macros.svh"

module diagCtl(
  input logic masterClk,
  input logic reset,
  input logic reqValid,
  input ebusPkg::tDiagReq req,
  output logic reqReady,
  input logic [`EBUS_DATA_W-1:0] ebusData,
  output ebusPkg::tEbusCmd cmd,
  output logic respValid,
  input logic respReady,
  output ebusPkg::tDiagResp resp
);

  ebusPkg::tDiagState state;
  logic reqTake;                // Request accepted this edge
  logic respTake;               // Response handed off this edge

  assign reqReady = (state == ebusPkg::IDLE); // One request in flight
  assign reqTake = reqValid && reqReady;
  assign respTake = respValid && respReady;

  always_ff @(posedge masterClk) begin
    if (reset) begin
      state <= ebusPkg::IDLE;
      cmd <= '0;                // Strobe low, no device selected
      respValid <= 1'b0;
      resp <= '0;
    end else begin
      case (state)
        ebusPkg::IDLE: begin
          if (reqTake) begin
            cmd.strobe <= 1'b1;   // Strobe during STROBE only
            cmd.cs <= req.cs;
            cmd.func <= req.func;
            cmd.data <= req.data;
            state <= ebusPkg::STROBE;
          end
        end

        ebusPkg::STROBE: begin
          cmd.strobe <= 1'b0;     // Exactly one strobe cycle
          state <= ebusPkg::SAMPLE;
        end

        ebusPkg::SAMPLE: begin
          // Selected device drives EBUS now if this was a read
          resp.data <= ebusData;  // Zero when nobody drives
          respValid <= 1'b1;
          state <= ebusPkg::RESP;
        end

        ebusPkg::RESP: begin
          if (respTake) begin
            respValid <= 1'b0;    // Response gone, ready again
            state <= ebusPkg::IDLE;
          end
        end

        default: begin
          state <= ebusPkg::IDLE; // Unreachable, all codes used
        end
      endcase
    end
  end

  // Command strobe only in the STROBE state
  strobeInStrobeState: assert property (
    @(posedge masterClk) disable iff (reset)
    cmd.strobe |-> (state == ebusPkg::STROBE)
  );

  // Back-pressure holds the response steady
  respHeldStable: assert property (
    @(posedge masterClk) disable iff (reset)
    (respValid && !respReady) |=> (respValid && $stable(resp))
  );

endmodule

//--- source/aprUnit.sv
`timescale 1ns/1ps
`include "ebus_macros.svh"

module aprUnit(
  input logic masterClk,
  input logic reset,
  input ebusPkg::tEbusCmd cmd,
  input logic timerDone,
  output ebusPkg::tEBUSdriver drv
);

  logic [`APR_FLAGS_W-1:0] flags;     // Condition flags
  logic [`APR_FLAGS_W-1:0] enables;   // Interrupt enable mask
  logic [`APR_FLAGS_W-1:0] flagsNext;
  logic selected;                     // Strobe addressed to APR
  logic intPending;                   // Any enabled flag set

  assign selected = cmd.strobe && (cmd.cs == `DEV_APR);
  assign intPending = |(flags & enables);

  // CONO clears first, then sets
  // timerDone forces flag 0 last so it beats a clear
  always_comb begin
    flagsNext = flags;
    if (selected && cmd.func == ebusPkg::CONO) begin
      flagsNext = flags & ~cmd.data[15:8];     // Clear mask
      flagsNext = flagsNext | cmd.data[7:0];   // Set mask
    end
    if (timerDone) begin
      flagsNext[0] = 1'b1;                     // Timer expiry flag
    end
  end

  always_ff @(posedge masterClk) begin
    if (reset) begin
      flags <= '0;
      enables <= '0;
    end else begin
      flags <= flagsNext;
      if (selected && cmd.func == ebusPkg::DATAO) begin
        enables <= cmd.data[7:0];              // New enable mask
      end
    end
  end

  // Read data on EBUS for the cycle after the strobe
  always_ff @(posedge masterClk) begin
    if (reset) begin
      drv <= '0;
    end else begin
      drv <= '0;                               // Off the bus by default
      if (selected) begin
        case (cmd.func)
          ebusPkg::DATAI: begin
            drv.driving <= 1'b1;
            drv.data <= {{(`EBUS_DATA_W-`APR_FLAGS_W){1'b0}}, enables};
          end
          ebusPkg::CONI: begin
            drv.driving <= 1'b1;
            drv.data <= {{(`EBUS_DATA_W-`APR_FLAGS_W-1){1'b0}}, intPending, flags};
          end
          default: begin
            drv.driving <= 1'b0;               // Writes return nothing
          end
        endcase
      end
    end
  end

  // One-cycle bus ownership
  drivingOneCycle: assert property (
    @(posedge masterClk) disable iff (reset)
    drv.driving |=> !drv.driving
  );

endmodule

//--- source/timerUnit.sv
`timescale 1ns/1ps
`include "ebus_macros.svh"

module timerUnit(
  input logic masterClk,
  input logic reset,
  input ebusPkg::tEbusCmd cmd,
  output logic timerDone,
  output ebusPkg::tEBUSdriver drv
);

  logic [`TIMER_W-1:0] period;        // Reload value
  logic [`TIMER_W-1:0] count;         // Down counter
  logic run;                          // Counting enabled
  logic done;                         // Sticky expiry flag
  logic selected;
  logic ticking;                      // Counter advances this cycle
  logic expire;                       // Count reaches the end

  assign selected = cmd.strobe && (cmd.cs == `DEV_TIMER);
  assign ticking = run && (period != '0);   // Zero period never expires
  assign expire = ticking && (count <= `TIMER_W'(1));

  always_ff @(posedge masterClk) begin
    if (reset) begin
      period <= '0;
      count <= '0;
      run <= 1'b0;                    // Stopped out of reset
      done <= 1'b0;
      timerDone <= 1'b0;
    end else begin
      timerDone <= expire;            // Single-cycle pulse to APR

      if (expire) begin
        count <= period;              // Reload on expiry
      end else if (ticking) begin
        count <= count - 1'b1;
      end

      if (selected && cmd.func == ebusPkg::CONO) begin
        run <= cmd.data[0];
        if (cmd.data[1]) begin
          done <= 1'b0;               // Acknowledge
        end
      end

      if (expire) begin
        done <= 1'b1;                 // Expiry beats acknowledge
      end

      // Software load overrides the running count
      if (selected && cmd.func == ebusPkg::DATAO) begin
        period <= cmd.data[`TIMER_W-1:0];
        count <= cmd.data[`TIMER_W-1:0];
      end
    end
  end

  always_ff @(posedge masterClk) begin
    if (reset) begin
      drv <= '0;
    end else begin
      drv <= '0;
      if (selected) begin
        case (cmd.func)
          ebusPkg::DATAI: begin
            drv.driving <= 1'b1;
            drv.data <= {{(`EBUS_DATA_W-`TIMER_W){1'b0}}, count};   // Live count
          end
          ebusPkg::CONI: begin
            drv.driving <= 1'b1;
            drv.data <= {{(`EBUS_DATA_W-2){1'b0}}, done, run};
          end
          default: begin
            drv.driving <= 1'b0;
          end
        endcase
      end
    end
  end

  // Pulse only comes from a running counter
  doneOnlyWhileRunning: assert property (
    @(posedge masterClk) disable iff (reset)
    timerDone |-> $past(run)
  );

endmodule

//--- source/edpUnit.sv
`timescale 1ns/1ps
`include "ebus_macros.svh"

module edpUnit(
  input logic masterClk,
  input logic reset,
  input ebusPkg::tEbusCmd cmd,
  output ebusPkg::tEBUSdriver drv
);

  logic [`EBUS_DATA_W-1:0] acc;       // Accumulator
  logic selected;
  logic accParity;                    // XOR of all accumulator bits

  assign selected = cmd.strobe && (cmd.cs == `DEV_EDP);
  assign accParity = ^acc;

  always_ff @(posedge masterClk) begin
    if (reset) begin
      acc <= '0;
    end else if (selected) begin
      case (cmd.func)
        ebusPkg::DATAO: begin
          acc <= acc + cmd.data;      // Wraps mod 2**36
        end
        ebusPkg::CONO: begin
          acc <= '0;                  // Clear
        end
        default: begin
          acc <= acc;                 // Reads leave it alone
        end
      endcase
    end
  end

  always_ff @(posedge masterClk) begin
    if (reset) begin
      drv <= '0;
    end else begin
      drv <= '0;
      if (selected) begin
        case (cmd.func)
          ebusPkg::DATAI: begin
            drv.driving <= 1'b1;
            drv.data <= acc;
          end
          ebusPkg::CONI: begin
            drv.driving <= 1'b1;
            drv.data <= {{(`EBUS_DATA_W-1){1'b0}}, accParity};   // Parity in bit 0
          end
          default: begin
            drv.driving <= 1'b0;
          end
        endcase
      end
    end
  end

  // Bus released after one cycle
  drivingOneCycle: assert property (
    @(posedge masterClk) disable iff (reset)
    drv.driving |=> !drv.driving
  );

endmodule

//--- source/top.sv
`timescale 1ns/1ps
`include "ebus_macros.svh"

module top(
  input logic masterClk,
  input logic reset,
  input logic reqValid,
  input ebusPkg::tDiagReq req,
  output logic reqReady,
  output logic respValid,
  input logic respReady,
  output ebusPkg::tDiagResp resp
);

  ebusPkg::tEbusCmd cmd;              // Broadcast command
  ebusPkg::tEBUSdriver aprDrv;
  ebusPkg::tEBUSdriver timerDrv;
  ebusPkg::tEBUSdriver edpDrv;
  logic [`EBUS_DATA_W-1:0] ebusData;  // Muxed EBUS
  logic timerDone;                    // Timer expiry into APR flag 0

  diagCtl diag0(
    .masterClk(masterClk),
    .reset(reset),
    .reqValid(reqValid),
    .req(req),
    .reqReady(reqReady),
    .ebusData(ebusData),
    .cmd(cmd),
    .respValid(respValid),
    .respReady(respReady),
    .resp(resp)
  );

  aprUnit apr0(
    .masterClk(masterClk),
    .reset(reset),
    .cmd(cmd),
    .timerDone(timerDone),
    .drv(aprDrv)
  );

  timerUnit timer0(
    .masterClk(masterClk),
    .reset(reset),
    .cmd(cmd),
    .timerDone(timerDone),
    .drv(timerDrv)
  );

  edpUnit edp0(
    .masterClk(masterClk),
    .reset(reset),
    .cmd(cmd),
    .drv(edpDrv)
  );

  // EBUS lives here so other bus masters could share it later
  always_comb begin
    if (aprDrv.driving) ebusData = aprDrv.data;           // Highest priority
    else if (timerDrv.driving) ebusData = timerDrv.data;
    else if (edpDrv.driving) ebusData = edpDrv.data;
    else ebusData = '0;                                   // Idle bus reads zero
  end

  // Single selected device means a single driver
  oneDriver: assert property (
    @(posedge masterClk) disable iff (reset)
    $onehot0({aprDrv.driving, timerDrv.driving, edpDrv.driving})
  );

endmodule

//--- dv/tbTop.sv
`timescale 1ns/1ps
`include "ebus_macros.svh"

module tbTop;

  localparam logic [`EBUS_DATA_W-1:0] fullMask = '1;

  logic masterClk;
  logic reset;
  logic reqValid;
  ebusPkg::tDiagReq req;
  logic reqReady;
  logic respValid;
  logic respReady;
  ebusPkg::tDiagResp resp;

  // Model of device register state
  logic [`EBUS_DATA_W-1:0] refAcc;
  logic [7:0] refFlags;
  logic [7:0] refEnables;
  logic [15:0] refPeriod;
  logic refRun;
  logic refDone;

  // Expected responses in issue order
  logic [`EBUS_DATA_W-1:0] expQ[$];
  logic [`EBUS_DATA_W-1:0] maskQ[$];
  string nameQ[$];
  logic [`EBUS_DATA_W-1:0] rdData;    // Scratch read result
  int i;

  top dut0(
    .masterClk(masterClk),
    .reset(reset),
    .reqValid(reqValid),
    .req(req),
    .reqReady(reqReady),
    .respValid(respValid),
    .respReady(respReady),
    .resp(resp)
  );

  initial begin
    masterClk = 1'b0;
    forever #4 masterClk = ~masterClk;  // 8 ns period
  end

  task automatic reportFailure(input string what);
    $display("ERROR: %s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [`EBUS_DATA_W-1:0] expected,
                            input logic [`EBUS_DATA_W-1:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [`EBUS_DATA_W-1:0] randomWord();
    logic [63:0] w;
    w = {$urandom, $urandom};
    return w[`EBUS_DATA_W-1:0];
  endfunction

  // Expected read value, updates model state on writes
  function automatic logic [`EBUS_DATA_W-1:0] refAccess(input logic [`EBUS_CS_W-1:0] cs,
      input ebusPkg::tEbusFunc func, input logic [`EBUS_DATA_W-1:0] data);
    logic [`EBUS_DATA_W-1:0] result;
    result = '0;                        // Writes and unused codes read zero
    case (cs)
      `DEV_APR: begin
        case (func)
          ebusPkg::DATAO: refEnables = data[7:0];
          ebusPkg::DATAI: result = {28'd0, refEnables};
          ebusPkg::CONO: refFlags = (refFlags & ~data[15:8]) | data[7:0];
          default: result = {27'd0, |(refFlags & refEnables), refFlags};
        endcase
      end
      `DEV_TIMER: begin
        case (func)
          ebusPkg::DATAO: refPeriod = data[15:0];
          ebusPkg::DATAI: result = {20'd0, refPeriod};   // Valid while stopped only
          ebusPkg::CONO: begin
            refRun = data[0];
            if (data[1]) refDone = 1'b0;
          end
          default: result = {34'd0, refDone, refRun};
        endcase
      end
      `DEV_EDP: begin
        case (func)
          ebusPkg::DATAO: refAcc = refAcc + data;       // Wraps at 36 bits
          ebusPkg::DATAI: result = refAcc;
          ebusPkg::CONO: refAcc = '0;
          default: result = {35'd0, ^refAcc};
        endcase
      end
      default: result = '0;
    endcase
    return result;
  endfunction

  // One request/response pair with handshake checks
  task automatic runCycle(input ebusPkg::tDiagReq r, output logic [`EBUS_DATA_W-1:0] got);
    int waitCount;
    int hold;
    logic [`EBUS_DATA_W-1:0] held;
    reqValid = 1'b1;
    req = r;
    waitCount = 0;
    while (!reqReady) begin
      @(posedge masterClk);
      #1;
      waitCount++;
      if (waitCount > 20) reportFailure("request was never accepted");
    end
    @(posedge masterClk);               // Accepting edge
    #1;
    reqValid = 1'b0;
    req = '0;
    waitCount = 1;                      // Accepting edge is the first
    while (!respValid) begin
      checkValue("reqReady low in flight", 0, reqReady);
      @(posedge masterClk);
      #1;
      waitCount++;
      if (waitCount > 10) reportFailure("no response after request");
    end
    checkValue("respValid latency", 3, waitCount);
    held = resp.data;
    hold = $urandom_range(0, 3);        // Back-pressure cycles
    repeat (hold) begin
      @(posedge masterClk);
      #1;
      checkValue("respValid held", 1, respValid);
      checkValue("resp data stable", held, resp.data);
      checkValue("reqReady low while resp waits", 0, reqReady);
    end
    respReady = 1'b1;
    @(posedge masterClk);               // Response transfer
    #1;
    respReady = 1'b0;
    checkValue("respValid after transfer", 0, respValid);
    checkValue("reqReady after transfer", 1, reqReady);
    got = held;
  endtask

  task automatic access(input logic [`EBUS_CS_W-1:0] cs, input ebusPkg::tEbusFunc func,
                        input logic [`EBUS_DATA_W-1:0] data,
                        input logic [`EBUS_DATA_W-1:0] mask, input string name,
                        output logic [`EBUS_DATA_W-1:0] got);
    ebusPkg::tDiagReq r;
    r.cs = cs;
    r.func = func;
    r.data = data;
    expQ.push_back(refAccess(cs, func, data));
    maskQ.push_back(mask);
    nameQ.push_back(name);
    runCycle(r, got);
  endtask

  // Timer expiry seen, so done and APR flag 0 are set
  function automatic void noteTimerDone();
    refDone = 1'b1;
    refFlags[0] = 1'b1;
  endfunction

  task automatic pollTimerDone(input int limit);
    int polls;
    logic [`EBUS_DATA_W-1:0] got;
    polls = 0;
    got = '0;
    while (!got[1]) begin
      if (polls >= limit) reportFailure("timer never reported done");
      access(`DEV_TIMER, ebusPkg::CONI, '0, ~36'h2, "timer CONI poll", got);
      polls++;
    end
    noteTimerDone();
  endtask

  // Compare at the negedge before each response transfer
  always @(negedge masterClk) begin : compareResp
    logic [`EBUS_DATA_W-1:0] expected;
    logic [`EBUS_DATA_W-1:0] mask;
    string name;
    if (!reset && respValid && respReady) begin
      if (expQ.size() == 0) reportFailure("response without a pending request");
      expected = expQ.pop_front();
      mask = maskQ.pop_front();
      name = nameQ.pop_front();
      checkValue(name, expected & mask, resp.data & mask);
    end
  end

  initial begin
    void'($urandom(32'ha2cdbea5));
    reset = 1'b1;
    reqValid = 1'b0;
    req = '0;
    respReady = 1'b0;
    refAcc = '0;
    refFlags = '0;
    refEnables = '0;
    refPeriod = '0;
    refRun = 1'b0;
    refDone = 1'b0;
    repeat (10) @(posedge masterClk);
    #1;
    reset = 1'b0;
    checkValue("reqReady after reset", 1, reqReady);
    checkValue("respValid after reset", 0, respValid);

    // EDP running sum, parity and clear
    access(`DEV_EDP, ebusPkg::CONO, '0, fullMask, "edp CONO", rdData);
    for (i = 0; i < 8; i++) begin
      access(`DEV_EDP, ebusPkg::DATAO, randomWord(), fullMask, "edp DATAO", rdData);
      access(`DEV_EDP, ebusPkg::DATAI, randomWord(), fullMask, "edp DATAI sum", rdData);
      access(`DEV_EDP, ebusPkg::CONI, '0, fullMask, "edp CONI parity", rdData);
    end
    access(`DEV_EDP, ebusPkg::DATAO, 36'hFFFFFFFFF, fullMask, "edp DATAO wrap", rdData);
    access(`DEV_EDP, ebusPkg::DATAI, '0, fullMask, "edp DATAI wrap", rdData);
    access(`DEV_EDP, ebusPkg::CONO, '0, fullMask, "edp CONO clear", rdData);
    access(`DEV_EDP, ebusPkg::DATAI, '0, fullMask, "edp DATAI after clear", rdData);

    // APR set/clear masks and interrupt status
    for (i = 0; i < 6; i++) begin
      access(`DEV_APR, ebusPkg::CONO, randomWord(), fullMask, "apr CONO", rdData);
      access(`DEV_APR, ebusPkg::DATAO, randomWord(), fullMask, "apr DATAO", rdData);
      access(`DEV_APR, ebusPkg::CONI, '0, fullMask, "apr CONI", rdData);
      access(`DEV_APR, ebusPkg::DATAI, '0, fullMask, "apr DATAI", rdData);
    end

    // Timer load, run to expiry, flag 0 in APR
    access(`DEV_APR, ebusPkg::CONO, 36'hFF00, fullMask, "apr CONO clear all", rdData);
    access(`DEV_TIMER, ebusPkg::DATAO, 36'd40, fullMask, "timer DATAO", rdData);
    access(`DEV_TIMER, ebusPkg::DATAI, '0, fullMask, "timer DATAI period", rdData);
    access(`DEV_TIMER, ebusPkg::CONI, '0, fullMask, "timer CONI stopped", rdData);
    access(`DEV_TIMER, ebusPkg::CONO, 36'h1, fullMask, "timer CONO start", rdData);
    pollTimerDone(30);
    access(`DEV_TIMER, ebusPkg::CONO, 36'h2, fullMask, "timer CONO stop", rdData);
    access(`DEV_APR, ebusPkg::CONI, '0, fullMask, "apr CONI timer flag", rdData);
    access(`DEV_TIMER, ebusPkg::CONI, '0, fullMask, "timer CONI cleared", rdData);

    // Zero period keeps running without expiry
    access(`DEV_TIMER, ebusPkg::DATAO, '0, fullMask, "timer DATAO zero", rdData);
    access(`DEV_TIMER, ebusPkg::CONO, 36'h1, fullMask, "timer CONO zero start", rdData);
    for (i = 0; i < 4; i++) begin
      access(`DEV_TIMER, ebusPkg::CONI, '0, fullMask, "timer CONI zero period", rdData);
    end
    access(`DEV_TIMER, ebusPkg::CONO, 36'h0, fullMask, "timer CONO halt", rdData);
    access(`DEV_TIMER, ebusPkg::DATAI, '0, fullMask, "timer DATAI zero", rdData);

    // Unused device codes read zero for every function
    for (i = 0; i < 8; i++) begin
      if (i == 0 || i > 3) begin
        access(3'(i), ebusPkg::DATAO, randomWord(), fullMask, "unused DATAO", rdData);
        access(3'(i), ebusPkg::DATAI, randomWord(), fullMask, "unused DATAI", rdData);
        access(3'(i), ebusPkg::CONO, randomWord(), fullMask, "unused CONO", rdData);
        access(3'(i), ebusPkg::CONI, randomWord(), fullMask, "unused CONI", rdData);
      end
    end
    access(`DEV_EDP, ebusPkg::DATAI, '0, fullMask, "edp DATAI untouched", rdData);
    access(`DEV_APR, ebusPkg::CONI, '0, fullMask, "apr CONI untouched", rdData);

    checkValue("pending responses", 0, expQ.size());
    $display("Test OK");
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
source/ebusPkg.sv
source/diagCtl.sv
source/aprUnit.sv
source/timerUnit.sv
source/edpUnit.sv
source/top.sv
dv/tbTop.sv
